// File: ad_clk_gen.sv
// ADC clock and conversion tick generator
`timescale 1ns/1ps

module ad_clk_gen (
  input  logic clk_sys,
  input  logic reset,
  input  logic pluse_us,
  output logic mclk,
  output logic mclk_fall,
  output logic conv_tick
);
  import ad_pkg::*;

  localparam int HALF_W = $clog2(MCLK_HALF);
  localparam int US_W   = $clog2(PERIOD_US);

  logic [HALF_W-1:0] half_cnt;
  logic [US_W-1:0]   us_cnt;

  // master clock, free running
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      half_cnt  <= '0;
      mclk      <= 1'b0;
      mclk_fall <= 1'b0;
    end else if (half_cnt == HALF_W'(MCLK_HALF - 1)) begin
      half_cnt  <= '0;
      mclk      <= ~mclk;
      // high in the first cycle mclk is low
      mclk_fall <= mclk;
    end else begin
      half_cnt  <= half_cnt + 1'b1;
      mclk_fall <= 1'b0;
    end
  end

  // conversion tick every PERIOD_US strobes
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      us_cnt    <= '0;
      conv_tick <= 1'b0;
    end else begin
      conv_tick <= 1'b0;
      if (pluse_us) begin
        if (us_cnt == US_W'(PERIOD_US - 1)) begin
          us_cnt    <= '0;
          conv_tick <= 1'b1;
        end else begin
          us_cnt <= us_cnt + 1'b1;
        end
      end
    end
  end

endmodule

// File: ad_mux.sv
// real or test pattern output select
`timescale 1ns/1ps

module ad_mux (
  input  logic               clk_sys,
  input  logic               reset,
  input  logic               tp_mode,
  input  ad_pkg::ad_sample_t real_smp,
  input  ad_pkg::ad_sample_t tp,
  output ad_pkg::ad_sample_t out
);
  import ad_pkg::*;

  logic                sel_vld;
  logic [SAMPLE_W-1:0] sel_data;
  logic [SAMPLE_W-1:0] out_data;
  logic                out_vld;

  // the unselected stream is dropped
  assign sel_vld  = tp_mode ? tp.vld  : real_smp.vld;
  assign sel_data = tp_mode ? tp.data : real_smp.data;

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      out_vld <= 1'b0;
    end else begin
      out_vld <= sel_vld;
    end
  end

  always_ff @(posedge clk_sys) begin
    if (sel_vld) begin
      out_data <= sel_data;
    end
  end

  assign out = '{data: out_data, vld: out_vld};

endmodule

// File: ad_pkg.sv
// ADC sample path definitions

package ad_pkg;

  // ------------------------------------------------------------------
  // sample format
  // ------------------------------------------------------------------

  // converter word width
  localparam int SAMPLE_W = 24;

  // configuration code sent in each frame
  localparam int CFG_W = 8;

  // ------------------------------------------------------------------
  // timing
  // ------------------------------------------------------------------

  // clk_sys cycles per half period of the master clock (50 MHz / 20)
  localparam int MCLK_HALF = 10;

  // microsecond strobes between conversions
  localparam int PERIOD_US = 500;

  // one sample as it moves down the data path
  typedef struct packed {
    logic [SAMPLE_W-1:0] data;
    logic                vld;
  } ad_sample_t;

endpackage

// File: ad_reg.sv
// ADC register bank on the fx bus
`timescale 1ns/1ps

module ad_reg (
  input  logic                          clk_sys,
  input  logic                          reset,
  input  fx_pkg::fx_req_t               fx,
  input  logic [fx_pkg::MOD_ID_W-1:0]   mod_id,
  output logic [fx_pkg::DATA_W-1:0]     fx_q,
  input  ad_pkg::ad_sample_t            last_sample,
  output fx_pkg::ad_cfg_t               cfg,
  output logic [ad_pkg::CFG_W-1:0]      cfg_sample
);
  import ad_pkg::*;
  import fx_pkg::*;

  logic                wr_hit;
  logic                rd_hit;
  logic [7:0]          wr_ofs;
  logic [7:0]          rd_ofs;
  logic [DATA_W-1:0]   rd_data;
  logic [SAMPLE_W-1:0] last_data;

  // slot decode, upper address bits carry the module id
  assign wr_hit = fx.wr && (fx.waddr[ADDR_W-1 -: MOD_ID_W] == mod_id);
  assign rd_hit = fx.rd && (fx.raddr[ADDR_W-1 -: MOD_ID_W] == mod_id);
  assign wr_ofs = fx.waddr[7:0];
  assign rd_ofs = fx.raddr[7:0];

  // ------------------------------------------------------------------
  // configuration writes
  // ------------------------------------------------------------------
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      cfg <= '{sample: CFG_SAMPLE_RST, default: '0};
    end else if (wr_hit) begin
      case (wr_ofs)
        REG_SAMPLE:   cfg.sample        <= fx.data;
        REG_TP_MODE:  cfg.tp_mode       <= fx.data[0];
        // base goes in LSB first
        REG_TP_BASE0: cfg.tp_base[7:0]   <= fx.data;
        REG_TP_BASE1: cfg.tp_base[15:8]  <= fx.data;
        REG_TP_BASE2: cfg.tp_base[23:16] <= fx.data;
        REG_TP_STEP:  cfg.tp_step       <= fx.data;
        default:      ;
      endcase
    end
  end

  assign cfg_sample = cfg.sample;

  // last delivered sample
  always_ff @(posedge clk_sys) begin
    if (last_sample.vld) begin
      last_data <= last_sample.data;
    end
  end

  // ------------------------------------------------------------------
  // read-back, one cycle after the read
  // ------------------------------------------------------------------
  always_comb begin
    case (rd_ofs)
      REG_SAMPLE:   rd_data = cfg.sample;
      REG_TP_MODE:  rd_data = {7'b0, cfg.tp_mode};
      REG_TP_BASE0: rd_data = cfg.tp_base[7:0];
      REG_TP_BASE1: rd_data = cfg.tp_base[15:8];
      REG_TP_BASE2: rd_data = cfg.tp_base[23:16];
      REG_TP_STEP:  rd_data = cfg.tp_step;
      REG_ID:       rd_data = ID_CODE;
      REG_DATA0:    rd_data = last_data[7:0];
      REG_DATA1:    rd_data = last_data[15:8];
      REG_DATA2:    rd_data = last_data[23:16];
      default:      rd_data = '0;
    endcase
  end

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      fx_q <= '0;
    end else begin
      fx_q <= rd_hit ? rd_data : '0;
    end
  end

endmodule

// File: ad_sample.sv
// ADC serial frame reader
`timescale 1ns/1ps

module ad_sample (
  input  logic               clk_sys,
  input  logic               reset,
  input  logic               mclk,
  input  logic               mclk_fall,
  input  logic               conv_tick,
  input  fx_pkg::ad_cfg_t    cfg,
  input  logic               ad_din,
  output logic               ad_clk,
  output logic               ad_sync,
  output logic               ad_cfg,
  output ad_pkg::ad_sample_t real_smp
);
  import ad_pkg::*;
  import fx_pkg::*;

  localparam int BIT_W  = $clog2(SAMPLE_W);
  localparam int CIDX_W = $clog2(CFG_W);

  typedef enum logic [1:0] {ST_IDLE, ST_SYNC, ST_SHIFT} state_t;

  state_t              state;
  state_t              state_d;
  logic [BIT_W-1:0]    bit_cnt;
  logic [BIT_W-1:0]    bit_cnt_d;
  logic [CIDX_W-1:0]   cfg_idx;
  logic                pending;
  logic                frame_start;
  logic                capture;
  logic [CFG_W-1:0]    cfg_lat;
  logic [SAMPLE_W-1:0] shreg;
  logic                smp_vld;

  // states only move on the falling edge of mclk
  always_comb begin
    state_d   = state;
    bit_cnt_d = bit_cnt;
    if (mclk_fall) begin
      case (state)
        ST_IDLE: begin
          if (pending) begin
            state_d = ST_SYNC;
          end
        end
        ST_SYNC: begin
          state_d   = ST_SHIFT;
          bit_cnt_d = '0;
        end
        ST_SHIFT: begin
          if (bit_cnt == BIT_W'(SAMPLE_W - 1)) begin
            state_d = ST_IDLE;
          end else begin
            bit_cnt_d = bit_cnt + 1'b1;
          end
        end
        default: state_d = ST_IDLE;
      endcase
    end
  end

  assign frame_start = (state == ST_IDLE) && (state_d == ST_SYNC);
  // ad_clk goes high on this edge
  assign capture     = (state == ST_SHIFT) && mclk && !ad_clk;
  assign cfg_idx     = CIDX_W'(CFG_W - 1) - bit_cnt_d[CIDX_W-1:0];

  // ------------------------------------------------------------------
  // control and pin registers
  // ------------------------------------------------------------------
  always_ff @(posedge clk_sys) begin
    if (reset) begin
      state   <= ST_IDLE;
      bit_cnt <= '0;
      pending <= 1'b0;
      ad_clk  <= 1'b0;
      ad_sync <= 1'b0;
      ad_cfg  <= 1'b0;
      smp_vld <= 1'b0;
    end else begin
      state   <= state_d;
      bit_cnt <= bit_cnt_d;
      if (conv_tick) begin
        pending <= 1'b1;
      end else if (frame_start) begin
        pending <= 1'b0;
      end
      ad_sync <= (state_d == ST_SYNC);
      ad_clk  <= (state_d == ST_SHIFT) && mclk;
      // code goes out MSB first in the first bit periods
      ad_cfg  <= (state_d == ST_SHIFT) && (bit_cnt_d < BIT_W'(CFG_W)) && cfg_lat[cfg_idx];
      smp_vld <= capture && (bit_cnt == BIT_W'(SAMPLE_W - 1));
    end
  end

  // code is frozen for the whole frame
  always_ff @(posedge clk_sys) begin
    if (frame_start) begin
      cfg_lat <= cfg.sample;
    end
  end

  always_ff @(posedge clk_sys) begin
    if (capture) begin
      shreg <= {shreg[SAMPLE_W-2:0], ad_din};
    end
  end

  assign real_smp = '{data: shreg, vld: smp_vld};

endmodule

// File: ad_top.sv
// ADC front end top level
`timescale 1ns/1ps

module ad_top (
  input  logic                          clk_sys,
  input  logic                          reset,
  input  logic                          pluse_us,
  input  logic                          ad_din,
  input  logic [fx_pkg::ADDR_W-1:0]     fx_waddr,
  input  logic                          fx_wr,
  input  logic [fx_pkg::DATA_W-1:0]     fx_data,
  input  logic                          fx_rd,
  input  logic [fx_pkg::ADDR_W-1:0]     fx_raddr,
  input  logic [fx_pkg::MOD_ID_W-1:0]   mod_id,
  output logic [fx_pkg::DATA_W-1:0]     fx_q,
  output logic                          ad_mclk,
  output logic                          ad_clk,
  output logic                          ad_cfg,
  output logic                          ad_sync,
  output logic [ad_pkg::SAMPLE_W-1:0]   ad_data,
  output logic                          ad_vld,
  output logic [ad_pkg::CFG_W-1:0]      cfg_sample
);
  import ad_pkg::*;
  import fx_pkg::*;

  logic       mclk;
  logic       mclk_fall;
  logic       conv_tick;
  fx_req_t    fx;
  ad_cfg_t    cfg;
  ad_sample_t real_smp;
  ad_sample_t tp_smp;
  ad_sample_t out_smp;

  assign fx = '{waddr: fx_waddr, wr: fx_wr, data: fx_data, rd: fx_rd, raddr: fx_raddr};

  // ------------------------------------------------------------------
  // clocks and registers
  // ------------------------------------------------------------------
  ad_clk_gen u_ad_clk_gen (
    .clk_sys   (clk_sys),
    .reset     (reset),
    .pluse_us  (pluse_us),
    .mclk      (mclk),
    .mclk_fall (mclk_fall),
    .conv_tick (conv_tick)
  );

  ad_reg u_ad_reg (
    .clk_sys     (clk_sys),
    .reset       (reset),
    .fx          (fx),
    .mod_id      (mod_id),
    .fx_q        (fx_q),
    .last_sample (out_smp),
    .cfg         (cfg),
    .cfg_sample  (cfg_sample)
  );

  // ------------------------------------------------------------------
  // data path
  // ------------------------------------------------------------------
  ad_sample u_ad_sample (
    .clk_sys   (clk_sys),
    .reset     (reset),
    .mclk      (mclk),
    .mclk_fall (mclk_fall),
    .conv_tick (conv_tick),
    .cfg       (cfg),
    .ad_din    (ad_din),
    .ad_clk    (ad_clk),
    .ad_sync   (ad_sync),
    .ad_cfg    (ad_cfg),
    .real_smp  (real_smp)
  );

  ad_tp u_ad_tp (
    .clk_sys   (clk_sys),
    .reset     (reset),
    .conv_tick (conv_tick),
    .cfg       (cfg),
    .tp        (tp_smp)
  );

  ad_mux u_ad_mux (
    .clk_sys  (clk_sys),
    .reset    (reset),
    .tp_mode  (cfg.tp_mode),
    .real_smp (real_smp),
    .tp       (tp_smp),
    .out      (out_smp)
  );

  assign ad_mclk = mclk;
  assign ad_data = out_smp.data;
  assign ad_vld  = out_smp.vld;

endmodule

// File: ad_tp.sv
// ramp test pattern source
`timescale 1ns/1ps

module ad_tp (
  input  logic               clk_sys,
  input  logic               reset,
  input  logic               conv_tick,
  input  fx_pkg::ad_cfg_t    cfg,
  output ad_pkg::ad_sample_t tp
);
  import ad_pkg::*;
  import fx_pkg::*;

  logic [SAMPLE_W-1:0] acc;
  logic [SAMPLE_W-1:0] tp_data;
  logic                tp_vld;

  // accumulator parks on the base outside test mode
  always_ff @(posedge clk_sys) begin
    if (!cfg.tp_mode) begin
      acc <= cfg.tp_base;
    end else if (conv_tick) begin
      // wraps at 2^24
      acc <= acc + SAMPLE_W'(cfg.tp_step);
    end
  end

  always_ff @(posedge clk_sys) begin
    if (cfg.tp_mode && conv_tick) begin
      tp_data <= acc;
    end
  end

  always_ff @(posedge clk_sys) begin
    if (reset) begin
      tp_vld <= 1'b0;
    end else begin
      tp_vld <= cfg.tp_mode && conv_tick;
    end
  end

  assign tp = '{data: tp_data, vld: tp_vld};

endmodule

// File: fx_pkg.sv
// fx bus and ADC configuration definitions

package fx_pkg;

  // bus geometry
  localparam int ADDR_W   = 16;
  localparam int DATA_W   = 8;
  localparam int MOD_ID_W = 6;

  // whole incoming bus in one bundle
  typedef struct packed {
    logic [ADDR_W-1:0] waddr;
    logic              wr;
    logic [DATA_W-1:0] data;
    logic              rd;
    logic [ADDR_W-1:0] raddr;
  } fx_req_t;

  // configuration held in the register bank
  typedef struct packed {
    logic [ad_pkg::CFG_W-1:0]    sample;
    logic                        tp_mode;
    logic [ad_pkg::SAMPLE_W-1:0] tp_base;
    logic [7:0]                  tp_step;
  } ad_cfg_t;

  // ------------------------------------------------------------------
  // register offsets, low address byte
  // ------------------------------------------------------------------
  localparam logic [7:0] REG_SAMPLE   = 8'h00;
  localparam logic [7:0] REG_TP_MODE  = 8'h01;
  localparam logic [7:0] REG_TP_BASE0 = 8'h02;
  localparam logic [7:0] REG_TP_BASE1 = 8'h03;
  localparam logic [7:0] REG_TP_BASE2 = 8'h04;
  localparam logic [7:0] REG_TP_STEP  = 8'h05;
  localparam logic [7:0] REG_ID       = 8'h10;
  localparam logic [7:0] REG_DATA0    = 8'h20;
  localparam logic [7:0] REG_DATA1    = 8'h21;
  localparam logic [7:0] REG_DATA2    = 8'h22;

  // read-only identity byte
  localparam logic [DATA_W-1:0] ID_CODE = 8'hAD;

  // rate and gain code after reset
  localparam logic [ad_pkg::CFG_W-1:0] CFG_SAMPLE_RST = 8'h40;

endpackage

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tb_ad_top -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_ad_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Simulation completed successfully"; then
  exit 0
fi
exit 1

// File: tb_ad_top.sv
// ADC front end testbench
`timescale 1ns/1ps

module tb_ad_top;
  import ad_pkg::*;
  import fx_pkg::*;

  localparam int          CLK_NS      = 20;
  localparam int          US_CYCLES   = 50;
  localparam int          TICK_CYCLES = PERIOD_US * US_CYCLES;
  localparam int          WAIT_CYCLES = 2 * TICK_CYCLES;
  // six conversion periods plus margin for reset and the last frame
  localparam int          WATCHDOG_NS = 6 * TICK_CYCLES * CLK_NS + 100_000;
  localparam logic [31:0] SEED        = 32'h9f5d1702;

  localparam logic [MOD_ID_W-1:0] MOD_ID   = 6'h2b;
  localparam logic [MOD_ID_W-1:0] OTHER_ID = 6'h14;

  logic                  clk_sys = 1'b0;
  logic                  reset;
  logic                  pluse_us = 1'b0;
  logic                  ad_din = 1'b0;
  logic [ADDR_W-1:0]     fx_waddr;
  logic                  fx_wr;
  logic [DATA_W-1:0]     fx_data;
  logic                  fx_rd;
  logic [ADDR_W-1:0]     fx_raddr;
  logic [MOD_ID_W-1:0]   mod_id;
  logic [DATA_W-1:0]     fx_q;
  logic                  ad_mclk;
  logic                  ad_clk;
  logic                  ad_cfg;
  logic                  ad_sync;
  logic [SAMPLE_W-1:0]   ad_data;
  logic                  ad_vld;
  logic [CFG_W-1:0]      cfg_sample;

  int                    errors = 0;
  logic [CFG_W-1:0]      sample_code;
  int                    us_div = 0;

  // converter model state
  logic [SAMPLE_W-1:0]   word_fifo [0:7];
  int                    push_cnt = 0;
  int                    pop_cnt = 0;
  logic [SAMPLE_W-1:0]   cur_word = '0;
  int                    bit_pos = 0;
  int                    rises = 0;
  int                    frame_syncs = 0;
  logic                  prev_clk = 1'b0;
  logic                  prev_sync = 1'b0;
  logic [CFG_W-1:0]      cfg_rec = '0;
  logic [CFG_W-1:0]      last_cfg = '0;
  int                    last_syncs = 0;
  int                    frames_done = 0;
  int                    model_errors = 0;

  ad_top DUT (
    .clk_sys    (clk_sys),
    .reset      (reset),
    .pluse_us   (pluse_us),
    .ad_din     (ad_din),
    .fx_waddr   (fx_waddr),
    .fx_wr      (fx_wr),
    .fx_data    (fx_data),
    .fx_rd      (fx_rd),
    .fx_raddr   (fx_raddr),
    .mod_id     (mod_id),
    .fx_q       (fx_q),
    .ad_mclk    (ad_mclk),
    .ad_clk     (ad_clk),
    .ad_cfg     (ad_cfg),
    .ad_sync    (ad_sync),
    .ad_data    (ad_data),
    .ad_vld     (ad_vld),
    .cfg_sample (cfg_sample)
  );

  always #(CLK_NS / 2) clk_sys = ~clk_sys;

  // microsecond strobe, one cycle in fifty
  always @(posedge clk_sys) begin
    if (reset || us_div == US_CYCLES - 1) begin
      us_div   <= 0;
      pluse_us <= !reset;
    end else begin
      us_div   <= us_div + 1;
      pluse_us <= 1'b0;
    end
  end

  // ------------------------------------------------------------------
  // converter model, pins seen as they were before the edge
  // ------------------------------------------------------------------
  always @(posedge clk_sys) begin
    if (ad_sync && !prev_sync) begin
      frame_syncs = frame_syncs + 1;
      cur_word    = '0;
      if (pop_cnt < push_cnt) begin
        cur_word = word_fifo[pop_cnt % 8];
        pop_cnt  = pop_cnt + 1;
      end
      bit_pos = SAMPLE_W - 1;
      rises   = 0;
      ad_din <= cur_word[SAMPLE_W-1];
    end
    if (ad_clk && !prev_clk) begin
      if (frame_syncs == 0) begin
        $display("ad_clk rose at %0t with no sync pulse before it", $time);
        model_errors = model_errors + 1;
      end
      if (rises < CFG_W) begin
        cfg_rec = {cfg_rec[CFG_W-2:0], ad_cfg};
      end
      rises = rises + 1;
      if (rises == SAMPLE_W) begin
        last_cfg    <= cfg_rec;
        last_syncs  <= frame_syncs;
        frames_done <= frames_done + 1;
        frame_syncs = 0;
      end
    end
    // next bit goes out after the falling edge
    if (!ad_clk && prev_clk && bit_pos > 0) begin
      bit_pos = bit_pos - 1;
      ad_din <= cur_word[bit_pos];
    end
    prev_clk  = ad_clk;
    prev_sync = ad_sync;
  end

  task automatic queue_word(input logic [SAMPLE_W-1:0] word);
    word_fifo[push_cnt % 8] = word;
    push_cnt = push_cnt + 1;
  endtask

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // ------------------------------------------------------------------
  // fx bus access
  // ------------------------------------------------------------------
  task automatic write_reg(input logic [MOD_ID_W-1:0] id, input logic [7:0] ofs,
                           input logic [7:0] val);
    @(posedge clk_sys);
    fx_waddr <= {id, 2'b00, ofs};
    fx_data  <= val;
    fx_wr    <= 1'b1;
    @(posedge clk_sys);
    fx_wr    <= 1'b0;
  endtask

  task automatic read_reg(input logic [MOD_ID_W-1:0] id, input logic [7:0] ofs,
                          output logic [7:0] val);
    @(posedge clk_sys);
    fx_raddr <= {id, 2'b00, ofs};
    fx_rd    <= 1'b1;
    @(posedge clk_sys);
    fx_rd    <= 1'b0;
    // data is on fx_q in the cycle after the read
    @(posedge clk_sys);
    val = fx_q;
  endtask

  task automatic expect_reg(input logic [MOD_ID_W-1:0] id, input logic [7:0] ofs,
                            input logic [7:0] exp, input string what);
    logic [7:0] val;
    read_reg(id, ofs, val);
    compare_value(what, 32'(val), 32'(exp));
  endtask

  task automatic wait_sample(output logic [SAMPLE_W-1:0] data);
    logic seen;
    int   n;
    seen = 1'b0;
    data = '0;
    for (n = 0; n < WAIT_CYCLES && !seen; n++) begin
      @(posedge clk_sys);
      if (ad_vld) begin
        seen = 1'b1;
        data = ad_data;
      end
    end
    if (!seen) begin
      errors++;
      $display("Timed out at %0t waiting for an output sample", $time);
    end
  endtask

  task automatic sync_to_frame_end();
    int start;
    int n;
    start = frames_done;
    for (n = 0; n < WAIT_CYCLES && frames_done == start; n++) begin
      @(posedge clk_sys);
    end
    if (frames_done == start) begin
      errors++;
      $display("Timed out at %0t waiting for a converter frame to end", $time);
    end
  endtask

  // ------------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------------
  task automatic reset_defaults();
    logic prev_mclk;
    int   toggles;
    compare_value("ad_mclk after reset", 32'(ad_mclk), 32'd0);
    prev_mclk = ad_mclk;
    toggles   = 0;
    repeat (40) begin
      @(posedge clk_sys);
      compare_value("vld, sync, cfg, clk while idle",
                    32'({ad_vld, ad_sync, ad_cfg, ad_clk}), 32'd0);
      if (ad_mclk !== prev_mclk) begin
        toggles++;
      end
      prev_mclk = ad_mclk;
    end
    // one toggle every half period
    compare_value("ad_mclk toggles in 40 cycles", 32'(toggles), 32'(40 / MCLK_HALF));
    compare_value("cfg_sample after reset", 32'(cfg_sample), 32'(CFG_SAMPLE_RST));
    expect_reg(MOD_ID, REG_SAMPLE, CFG_SAMPLE_RST, "REG_SAMPLE after reset");
    expect_reg(MOD_ID, REG_ID, ID_CODE, "REG_ID");
  endtask

  task automatic register_access();
    logic [7:0]          code;
    logic [SAMPLE_W-1:0] base;
    logic [7:0]          step;
    code = 8'($urandom);
    base = 24'($urandom);
    step = 8'($urandom);
    write_reg(MOD_ID, REG_SAMPLE, code);
    write_reg(MOD_ID, REG_TP_MODE, 8'h01);
    expect_reg(MOD_ID, REG_TP_MODE, 8'h01, "REG_TP_MODE set");
    write_reg(MOD_ID, REG_TP_MODE, 8'h00);
    write_reg(MOD_ID, REG_TP_BASE0, base[7:0]);
    write_reg(MOD_ID, REG_TP_BASE1, base[15:8]);
    write_reg(MOD_ID, REG_TP_BASE2, base[23:16]);
    write_reg(MOD_ID, REG_TP_STEP, step);
    expect_reg(MOD_ID, REG_SAMPLE, code, "REG_SAMPLE");
    expect_reg(MOD_ID, REG_TP_MODE, 8'h00, "REG_TP_MODE");
    expect_reg(MOD_ID, REG_TP_BASE0, base[7:0], "REG_TP_BASE0");
    expect_reg(MOD_ID, REG_TP_BASE1, base[15:8], "REG_TP_BASE1");
    expect_reg(MOD_ID, REG_TP_BASE2, base[23:16], "REG_TP_BASE2");
    expect_reg(MOD_ID, REG_TP_STEP, step, "REG_TP_STEP");
    compare_value("cfg_sample", 32'(cfg_sample), 32'(code));
    // another slot must not touch this bank
    write_reg(OTHER_ID, REG_SAMPLE, ~code);
    write_reg(OTHER_ID, REG_TP_STEP, ~step);
    expect_reg(MOD_ID, REG_SAMPLE, code, "REG_SAMPLE after foreign write");
    expect_reg(MOD_ID, REG_TP_STEP, step, "REG_TP_STEP after foreign write");
    expect_reg(OTHER_ID, REG_ID, 8'h00, "read from another slot");
    sample_code = code;
  endtask

  task automatic real_capture();
    logic [SAMPLE_W-1:0] word;
    logic [SAMPLE_W-1:0] got;
    repeat (2) begin
      word = 24'($urandom);
      queue_word(word);
      wait_sample(got);
      compare_value("captured word", 32'(got), 32'(word));
      expect_reg(MOD_ID, REG_DATA0, word[7:0], "REG_DATA0");
      expect_reg(MOD_ID, REG_DATA1, word[15:8], "REG_DATA1");
      expect_reg(MOD_ID, REG_DATA2, word[23:16], "REG_DATA2");
    end
  endtask

  task automatic config_frame();
    compare_value("cfg bits in last frame", 32'(last_cfg), 32'(sample_code));
    compare_value("sync pulses in last frame", 32'(last_syncs), 32'd1);
  endtask

  task automatic ramp_pattern();
    logic [SAMPLE_W-1:0] base;
    logic [7:0]          step;
    logic [SAMPLE_W-1:0] exp;
    logic [SAMPLE_W-1:0] got;
    // base close to the top so the ramp wraps on the first step
    step = 8'd128 + 8'($urandom % 128);
    base = 24'hffffff - 24'($urandom % 128);
    write_reg(MOD_ID, REG_TP_BASE0, base[7:0]);
    write_reg(MOD_ID, REG_TP_BASE1, base[15:8]);
    write_reg(MOD_ID, REG_TP_BASE2, base[23:16]);
    write_reg(MOD_ID, REG_TP_STEP, step);
    write_reg(MOD_ID, REG_TP_MODE, 8'h01);
    exp = base;
    repeat (3) begin
      wait_sample(got);
      compare_value("ramp value", 32'(got), 32'(exp));
      exp = exp + 24'(step);
    end
  endtask

  task automatic back_to_real();
    logic [SAMPLE_W-1:0] word;
    logic [SAMPLE_W-1:0] got;
    // frame of the last ramp tick is dropped while still in test mode
    sync_to_frame_end();
    write_reg(MOD_ID, REG_TP_MODE, 8'h00);
    word = 24'($urandom);
    queue_word(word);
    wait_sample(got);
    compare_value("real word after ramp", 32'(got), 32'(word));
  endtask

  initial begin
    void'($urandom(SEED));
    reset    = 1'b1;
    mod_id   = MOD_ID;
    fx_waddr = '0;
    fx_wr    = 1'b0;
    fx_data  = '0;
    fx_rd    = 1'b0;
    fx_raddr = '0;
    repeat (10) @(posedge clk_sys);
    reset <= 1'b0;
    @(posedge clk_sys);
    reset_defaults();
    register_access();
    real_capture();
    config_frame();
    ramp_pattern();
    back_to_real();
    $display("Errors: %0d", errors + model_errors);
    if (errors + model_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0t before the tests finished", $time);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: verilog.f
ad_pkg.sv
fx_pkg.sv
ad_clk_gen.sv
ad_reg.sv
ad_sample.sv
ad_tp.sv
ad_mux.sv
ad_top.sv
tb_ad_top.sv
